// File: logic/serial_read_pkg.sv
`default_nettype none

package serial_read_pkg;

    // ------------------------------------------------------------
    // Widths and FIFO sizing
    // ------------------------------------------------------------
    localparam int INDEX_WIDTH          = 32;
    localparam int ADDR_WIDTH           = 32;
    localparam int SHIFT_WIDTH          = 5;
    localparam int REQ_FIFO_DEPTH       = 16;
    localparam int REQ_FIFO_PROG_THRESH = 8;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------
    // Array index or index step
    typedef logic [INDEX_WIDTH-1:0] index_t;
    // Byte address or byte offset
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    // Bit positions the index moves to form the offset
    typedef logic [SHIFT_WIDTH-1:0] shift_t;
    // Fill count, 0 up to and including the depth
    typedef logic [$clog2(REQ_FIFO_DEPTH+1)-1:0] fifo_level_t;

    // Job sequencer states
    typedef enum logic [3:0] {
        RESET,
        IDLE,
        SETUP,
        START,
        BUSY,
        BUSY_TRANS,
        PAUSE_TRANS,
        PAUSE,
        DONE
    } seq_state_t;

endpackage

`default_nettype wire

// File: logic/req_push_if.sv
`timescale 1ns/100ps
`default_nettype none

interface req_push_if;
    import serial_read_pkg::*;

    // Write side of the request FIFO
    logic   push;
    addr_t  base;
    addr_t  offset;
    index_t index;

    // Fill flags back to the sequencer
    logic   prog_full;
    logic   full;

    modport producer (
        output push,
        output base,
        output offset,
        output index,
        input  prog_full,
        input  full
    );

    modport consumer (
        input  push,
        input  base,
        input  offset,
        input  index,
        output prog_full,
        output full
    );

endinterface

`default_nettype wire

// File: logic/read_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module read_sequencer (
    input  logic                    ap_clk,
    input  logic                    areset_engine,
    input  logic                    start_in,
    input  logic                    pause_in,
    input  serial_read_pkg::addr_t  array_pointer,
    input  serial_read_pkg::index_t start_read,
    input  serial_read_pkg::index_t end_read,
    input  serial_read_pkg::index_t stride,
    input  logic                    shift_left,
    input  serial_read_pkg::shift_t shift_amount,
    output logic                    ready_out,
    output logic                    done_out,
    req_push_if.producer            push
);
    import serial_read_pkg::*;

    // ------------------------------------------------------------
    // Registered inputs
    // ------------------------------------------------------------
    logic   start_reg;
    logic   pause_reg;
    addr_t  base_reg;
    index_t start_read_reg;
    index_t end_read_reg;
    index_t stride_reg;
    logic   shift_left_reg;
    shift_t shift_amount_reg;

    seq_state_t state;
    seq_state_t next_state;

    // Index counter and its carry guard
    index_t               idx;
    logic                 idx_wrap;
    logic [INDEX_WIDTH:0] idx_sum;

    logic  in_range;
    logic  stop_req;
    logic  gen;
    addr_t offset_comb;

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            start_reg <= 1'b0;
            pause_reg <= 1'b0;
        end else begin
            start_reg <= start_in;
            pause_reg <= pause_in;
        end
    end

    // Job config, held stable by the host while start_in is high
    always_ff @(posedge ap_clk) begin
        base_reg         <= array_pointer;
        start_read_reg   <= start_read;
        end_read_reg     <= end_read;
        stride_reg       <= stride;
        shift_left_reg   <= shift_left;
        shift_amount_reg <= shift_amount;
    end

    // ------------------------------------------------------------
    // Job state machine
    // ------------------------------------------------------------
    assign in_range = !idx_wrap && (idx < end_read_reg);
    assign stop_req = push.prog_full || pause_reg;

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET:       next_state = IDLE;
            IDLE:        if (start_reg) next_state = SETUP;
            SETUP:       next_state = START;
            START:       next_state = BUSY;
            BUSY: begin
                if (!in_range) begin
                    next_state = DONE;
                end else if (stop_req) begin
                    next_state = PAUSE_TRANS;
                end
            end
            PAUSE_TRANS: next_state = PAUSE;
            PAUSE:       if (!stop_req) next_state = BUSY_TRANS;
            BUSY_TRANS:  next_state = BUSY;
            // Hold until the host drops its request
            DONE:        if (!start_reg) next_state = IDLE;
            default:     next_state = RESET;
        endcase
    end

    assign ready_out = (state == IDLE);
    assign done_out  = (state == DONE);

    // ------------------------------------------------------------
    // Index counter and request formation
    // ------------------------------------------------------------
    // One last request slips out while the pause takes hold
    assign gen = in_range && ((state == BUSY && !stop_req) || state == PAUSE_TRANS);

    assign idx_sum = {1'b0, idx} + {1'b0, stride_reg};

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            idx      <= '0;
            idx_wrap <= 1'b0;
        end else if (state == SETUP) begin
            idx      <= start_read_reg;
            idx_wrap <= 1'b0;
        end else if (gen) begin
            idx      <= idx_sum[INDEX_WIDTH-1:0];
            // Stop cleanly if the step runs past the top of the index space
            idx_wrap <= idx_sum[INDEX_WIDTH];
        end
    end

    always_comb begin
        if (shift_left_reg) begin
            offset_comb = addr_t'(idx) << shift_amount_reg;
        end else begin
            offset_comb = addr_t'(idx) >> shift_amount_reg;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            push.push <= 1'b0;
        end else begin
            push.push <= gen;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (gen) begin
            push.base   <= base_reg;
            push.offset <= offset_comb;
            push.index  <= idx;
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // Registered push must already be quiet once the job has ended
    a_no_push_idle_done: assert property (@(posedge ap_clk) disable iff (areset_engine)
        (state == IDLE || state == DONE) |-> !push.push);

    // prog_full margin keeps the FIFO from ever filling
    a_no_push_full: assert property (@(posedge ap_clk) disable iff (areset_engine)
        push.push |-> !push.full);

    a_stride_nonzero: assert property (@(posedge ap_clk) disable iff (areset_engine)
        (state == SETUP) |-> (stride_reg != '0));

endmodule

`default_nettype wire

// File: logic/request_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module request_fifo (
    input  logic                    ap_clk,
    input  logic                    areset_engine,
    req_push_if.consumer            push,
    input  logic                    request_ready,
    output logic                    request_valid,
    output serial_read_pkg::addr_t  request_base,
    output serial_read_pkg::addr_t  request_offset,
    output serial_read_pkg::index_t request_index
);
    import serial_read_pkg::*;

    // ------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------
    addr_t  mem_base   [REQ_FIFO_DEPTH];
    addr_t  mem_offset [REQ_FIFO_DEPTH];
    index_t mem_index  [REQ_FIFO_DEPTH];

    // Depth is a power of two, so pointers wrap on their own
    logic [$clog2(REQ_FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(REQ_FIFO_DEPTH)-1:0] rd_ptr;
    fifo_level_t                       count;

    logic pop;

    assign pop = request_valid && request_ready;

    always_ff @(posedge ap_clk) begin
        if (push.push) begin
            mem_base[wr_ptr]   <= push.base;
            mem_offset[wr_ptr] <= push.offset;
            mem_index[wr_ptr]  <= push.index;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push.push, pop})
                2'b10:   count <= count + fifo_level_t'(1);
                2'b01:   count <= count - fifo_level_t'(1);
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Flags and show-ahead head
    // ------------------------------------------------------------
    assign push.full      = (count == REQ_FIFO_DEPTH);
    assign push.prog_full = (count >= REQ_FIFO_PROG_THRESH);

    assign request_valid  = (count != '0);
    assign request_base   = mem_base[rd_ptr];
    assign request_offset = mem_offset[rd_ptr];
    assign request_index  = mem_index[rd_ptr];

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_no_write_full: assert property (@(posedge ap_clk) disable iff (areset_engine)
        push.push |-> (count != REQ_FIFO_DEPTH));

    // Stalled head holds until the consumer takes it
    a_head_stable: assert property (@(posedge ap_clk) disable iff (areset_engine)
        (request_valid && !request_ready) |=>
            (request_valid && $stable(request_base) && $stable(request_offset)
             && $stable(request_index)));

endmodule

`default_nettype wire

// File: logic/serial_read_engine.sv
`timescale 1ns/100ps
`default_nettype none

module serial_read_engine (
    input  logic                    ap_clk,
    input  logic                    areset_engine,

    // Job handshake and configuration
    input  logic                    start_in,
    input  logic                    pause_in,
    input  serial_read_pkg::addr_t  array_pointer,
    input  serial_read_pkg::index_t start_read,
    input  serial_read_pkg::index_t end_read,
    input  serial_read_pkg::index_t stride,
    input  logic                    shift_left,
    input  serial_read_pkg::shift_t shift_amount,
    output logic                    ready_out,
    output logic                    done_out,

    // Read request stream
    input  logic                    request_ready,
    output logic                    request_valid,
    output serial_read_pkg::addr_t  request_base,
    output serial_read_pkg::addr_t  request_offset,
    output serial_read_pkg::index_t request_index
);

    // ------------------------------------------------------------
    // Sequencer to FIFO link
    // ------------------------------------------------------------
    req_push_if push_bus ();

    // ------------------------------------------------------------
    // Request generation
    // ------------------------------------------------------------
    read_sequencer u_read_sequencer (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .start_in      (start_in),
        .pause_in      (pause_in),
        .array_pointer (array_pointer),
        .start_read    (start_read),
        .end_read      (end_read),
        .stride        (stride),
        .shift_left    (shift_left),
        .shift_amount  (shift_amount),
        .ready_out     (ready_out),
        .done_out      (done_out),
        .push          (push_bus.producer)
    );

    // ------------------------------------------------------------
    // Request buffering
    // ------------------------------------------------------------
    request_fifo u_request_fifo (
        .ap_clk         (ap_clk),
        .areset_engine  (areset_engine),
        .push           (push_bus.consumer),
        .request_ready  (request_ready),
        .request_valid  (request_valid),
        .request_base   (request_base),
        .request_offset (request_offset),
        .request_index  (request_index)
    );

endmodule

`default_nettype wire

// File: testbench/tb_serial_read_engine.sv
`timescale 1ns/100ps
`default_nettype none

module tb_serial_read_engine;

    localparam int NUM_JOBS        = 8;
    localparam int HANDSHAKE_BOUND = 8;

    // One row of the job table
    typedef struct packed {
        logic [31:0] ptr;
        logic [31:0] first;
        logic [31:0] last;
        logic [31:0] step;
        logic        left;
        logic [4:0]  amt;
        logic [15:0] pause_pat;
        logic [31:0] ready_pct;
    } job_t;

    logic        ap_clk;
    logic        areset_engine;
    logic        start_in;
    logic        pause_in;
    logic [31:0] array_pointer;
    logic [31:0] start_read;
    logic [31:0] end_read;
    logic [31:0] stride;
    logic        shift_left;
    logic [4:0]  shift_amount;
    logic        ready_out;
    logic        done_out;
    logic        request_ready;
    logic        request_valid;
    logic [31:0] request_base;
    logic [31:0] request_offset;
    logic [31:0] request_index;

    job_t        jobs [NUM_JOBS];
    logic [31:0] exp_index [$];
    logic [31:0] exp_offset [$];
    logic [31:0] exp_base;
    int          rx_count;
    int          cur_job;
    int          job_cycle;
    int          cycle_count = 0;
    int          cycle_limit = 1000000;
    integer      seed = 32'hf843b57e;

    serial_read_engine UUT (
        .ap_clk         (ap_clk),
        .areset_engine  (areset_engine),
        .start_in       (start_in),
        .pause_in       (pause_in),
        .array_pointer  (array_pointer),
        .start_read     (start_read),
        .end_read       (end_read),
        .stride         (stride),
        .shift_left     (shift_left),
        .shift_amount   (shift_amount),
        .ready_out      (ready_out),
        .done_out       (done_out),
        .request_ready  (request_ready),
        .request_valid  (request_valid),
        .request_base   (request_base),
        .request_offset (request_offset),
        .request_index  (request_index)
    );

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Run took more than %0d clock cycles and was stopped", cycle_limit);
            abort_run();
        end
    end

    // ------------------------------------------------------------
    // Checking helpers
    // ------------------------------------------------------------
    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // ptr, first, last, step, left, amt, pause pattern, ready percent
    task automatic load_jobs();
        jobs[0] = '{32'h1000_0000, 32'd0, 32'd10, 32'd1, 1'b1, 5'd2, 16'h0000, 32'd100};
        jobs[1] = '{32'h2000_0000, 32'd3, 32'd40, 32'd3, 1'b1, 5'd3, 16'h0001, 32'd75};
        jobs[2] = '{32'h3000_0040, 32'd100, 32'd164, 32'd4, 1'b0, 5'd2, 16'h0000, 32'd50};
        // Empty ranges
        jobs[3] = '{32'h4000_0000, 32'd20, 32'd20, 32'd1, 1'b1, 5'd0, 16'h0000, 32'd100};
        jobs[4] = '{32'h5000_0000, 32'd50, 32'd10, 32'd2, 1'b0, 5'd1, 16'h0000, 32'd100};
        // Heavy back-pressure plus pause bursts
        jobs[5] = '{32'h6000_0100, 32'd0, 32'd60, 32'd1, 1'b1, 5'd4, 16'hf0f0, 32'd10};
        jobs[6] = '{32'h7000_0000, 32'd7, 32'd200, 32'd5, 1'b0, 5'd1, 16'h0c30, 32'd60};
        // Step runs off the top of the index space
        jobs[7] = '{32'h8000_0000, 32'hffff_fff0, 32'hffff_ffff, 32'd4, 1'b1, 5'd3,
                    16'h0000, 32'd90};
    endtask

    // Index walk from first while below last, offset is the shifted index
    task automatic build_expected(input int j);
        logic [63:0] i;
        logic [31:0] idx32;
        logic [31:0] off;
        exp_index.delete();
        exp_offset.delete();
        i = {32'd0, jobs[j].first};
        while (i < {32'd0, jobs[j].last}) begin
            idx32 = i[31:0];
            if (jobs[j].left) begin
                off = idx32 << jobs[j].amt;
            end else begin
                off = idx32 >> jobs[j].amt;
            end
            exp_index.push_back(idx32);
            exp_offset.push_back(off);
            i = i + {32'd0, jobs[j].step};
        end
    endtask

    // ------------------------------------------------------------
    // Per-cycle driving and request capture
    // ------------------------------------------------------------
    task automatic step_cycle();
        logic [31:0] draw;
        @(negedge ap_clk);
        draw          = $random(seed);
        request_ready = ((draw % 32'd100) < jobs[cur_job].ready_pct);
        pause_in      = jobs[cur_job].pause_pat[job_cycle[3:0]];
        job_cycle     = job_cycle + 1;
        // Head is taken on the coming rising edge
        if (request_valid && request_ready) begin
            if (rx_count >= exp_index.size()) begin
                check_value("request_count", 64'(exp_index.size()), 64'(rx_count + 1));
            end else begin
                check_value("request_base", 64'(exp_base), 64'(request_base));
                check_value("request_offset", 64'(exp_offset[rx_count]), 64'(request_offset));
                check_value("request_index", 64'(exp_index[rx_count]), 64'(request_index));
            end
            rx_count = rx_count + 1;
        end
    endtask

    task automatic run_job(input int j);
        int waited;
        build_expected(j);
        exp_base  = jobs[j].ptr;
        rx_count  = 0;
        cur_job   = j;
        job_cycle = 0;
        step_cycle();
        check_value("ready_out", 64'd1, 64'(ready_out));
        array_pointer = jobs[j].ptr;
        start_read    = jobs[j].first;
        end_read      = jobs[j].last;
        stride        = jobs[j].step;
        shift_left    = jobs[j].left;
        shift_amount  = jobs[j].amt;
        start_in      = 1'b1;

        while (!done_out) begin
            step_cycle();
        end
        // Drain while the host keeps start_in high
        while (rx_count < exp_index.size()) begin
            step_cycle();
            check_value("done_out", 64'd1, 64'(done_out));
        end
        repeat (4) begin
            step_cycle();
            check_value("done_out", 64'd1, 64'(done_out));
            check_value("request_valid", 64'd0, 64'(request_valid));
        end

        start_in = 1'b0;
        waited   = 0;
        while (done_out || !ready_out) begin
            if (waited >= HANDSHAKE_BOUND) begin
                $display("Job %0d: done_out did not fall or ready_out did not rise", j);
                abort_run();
            end
            step_cycle();
            waited = waited + 1;
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int total;
        int waited;
        areset_engine = 1'b1;
        start_in      = 1'b0;
        pause_in      = 1'b0;
        array_pointer = '0;
        start_read    = '0;
        end_read      = '0;
        stride        = 32'd1;
        shift_left    = 1'b0;
        shift_amount  = '0;
        request_ready = 1'b0;

        load_jobs();
        total = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            build_expected(j);
            total = total + exp_index.size();
        end
        cycle_limit = 50 * total + 100 * NUM_JOBS;
        exp_index.delete();
        exp_offset.delete();
        rx_count  = 0;
        cur_job   = 0;
        job_cycle = 0;

        repeat (4) @(negedge ap_clk);
        check_value("ready_out", 64'd0, 64'(ready_out));
        check_value("done_out", 64'd0, 64'(done_out));
        check_value("request_valid", 64'd0, 64'(request_valid));
        areset_engine = 1'b0;

        waited = 0;
        while (!ready_out) begin
            if (waited >= HANDSHAKE_BOUND) begin
                $display("ready_out did not rise after reset was released");
                abort_run();
            end
            step_cycle();
            waited = waited + 1;
        end
        check_value("done_out", 64'd0, 64'(done_out));
        check_value("request_valid", 64'd0, 64'(request_valid));

        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
logic/serial_read_pkg.sv
logic/req_push_if.sv
logic/read_sequencer.sv
logic/request_fifo.sv
logic/serial_read_engine.sv
testbench/tb_serial_read_engine.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the serial read engine testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_serial_read_engine \
    -f sim.f \
    -o tb_serial_read_engine

./obj_dir/tb_serial_read_engine
